// ==== Makefile ====
# Verilator flow for the mailbox testbench

TOP := tb_mbox
OBJ := obj_dir

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f tb.f

sim:
	verilator --binary --assert --top-module $(TOP) -Mdir $(OBJ) -f tb.f
	./$(OBJ)/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf $(OBJ) sim.log

// ==== design/mbox_credit_ctrl.sv ====
// Mailbox credit controller
// Tracks the credits held by the host, returns one credit per pop
// and flags a push made without a credit

`timescale 1ns/10ps
`include "mbox_defines.svh"

module mbox_credit_ctrl (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic push_i,
  input  logic push_ok_i,
  input  logic pop_ok_i,
  output logic credit_o,
  output logic err_overflow_o
);

  mbox_pkg::count_t credit_q;
  logic             credit_ret_q;
  logic             err_q;
  logic             no_credit;

  assign no_credit = (credit_q == '0);

  // Host credits, one per free slot
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      credit_q <= mbox_pkg::count_t'(`MBOX_DEPTH);
    end else begin
      case ({push_ok_i, pop_ok_i})
        2'b10:   credit_q <= credit_q - 1'b1;
        2'b01:   credit_q <= credit_q + 1'b1;
        default: credit_q <= credit_q;
      endcase
    end
  end

  // Return pulse in the cycle after a pop
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      credit_ret_q <= 1'b0;
    end else begin
      credit_ret_q <= pop_ok_i;
    end
  end

  // Sticky until reset
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      err_q <= 1'b0;
    end else if (push_i && (!push_ok_i || no_credit)) begin
      err_q <= 1'b1;
    end
  end

  assign credit_o       = credit_ret_q;
  assign err_overflow_o = err_q;

endmodule

// ==== design/mbox_defines.svh ====
// Mailbox sizing constants
// Queue depth, message width and the pointer and count widths

`ifndef MBOX_DEFINES_SVH
`define MBOX_DEFINES_SVH

// Message slots, also the credits the host holds after reset
`define MBOX_DEPTH 4

// Message width in bits
`define MBOX_MSG_W 32

// Slot index width
`define MBOX_PTR_W 2

// Fill and credit counts must reach MBOX_DEPTH
`define MBOX_CNT_W 3

`endif

// ==== design/mbox_fifo.sv ====
// Mailbox message queue
// Circular buffer of MBOX_DEPTH slots with read and write pointers
// and a fill count. Reports which transfers were really taken.

`timescale 1ns/10ps
`include "mbox_defines.svh"

module mbox_fifo (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             push_i,
  input  mbox_pkg::msg_t   msg_i,
  input  logic             pop_i,
  output mbox_pkg::msg_t   msg_o,
  output logic             valid_o,
  output logic             push_ok_o,
  output logic             pop_ok_o,
  output mbox_pkg::count_t count_o
);

  mbox_pkg::msg_t   mem_q [`MBOX_DEPTH];
  mbox_pkg::ptr_t   wr_ptr_q;
  mbox_pkg::ptr_t   rd_ptr_q;
  mbox_pkg::count_t count_q;
  logic             full;
  logic             empty;

  assign full  = (count_q == mbox_pkg::count_t'(`MBOX_DEPTH));
  assign empty = (count_q == '0);

  // Accepted transfers
  assign push_ok_o = push_i & ~full;
  assign pop_ok_o  = pop_i & ~empty;

  assign valid_o = ~empty;
  assign msg_o   = mem_q[rd_ptr_q];
  assign count_o = count_q;

  // Storage
  always_ff @(posedge clk_i) begin
    if (push_ok_o) begin
      mem_q[wr_ptr_q] <= msg_i;
    end
  end

  // Pointers wrap at the depth
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (push_ok_o) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_ok_o) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  // Fill count, unchanged on push and pop together
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      count_q <= '0;
    end else begin
      case ({push_ok_o, pop_ok_o})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

// ==== design/mbox_irq_fsm.sv ====
// Mailbox interrupt FSM
// Raises the doorbell while messages wait and the completion
// interrupt once the cluster has drained the queue

`timescale 1ns/10ps

module mbox_irq_fsm (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  mbox_pkg::count_t count_i,
  input  logic             clr_i,
  output logic             doorbell_irq_o,
  output logic             completion_irq_o
);

  mbox_pkg::irq_state_t state_q;
  mbox_pkg::irq_state_t state_d;
  logic                 pending;
  logic                 doorbell_q;
  logic                 completion_q;

  assign pending = (count_i != '0);

  always_comb begin
    state_d = state_q;
    case (state_q)
      mbox_pkg::IRQ_IDLE: begin
        if (pending) begin
          state_d = mbox_pkg::IRQ_RING;
        end
      end
      mbox_pkg::IRQ_RING: begin
        if (!pending) begin
          state_d = mbox_pkg::IRQ_DONE;
        end
      end
      mbox_pkg::IRQ_DONE: begin
        // Host acknowledge, ring again if new messages arrived
        if (clr_i) begin
          state_d = pending ? mbox_pkg::IRQ_RING : mbox_pkg::IRQ_IDLE;
        end
      end
      default: state_d = mbox_pkg::IRQ_IDLE;
    endcase
  end

  // Outputs follow the next state so they switch with it
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q      <= mbox_pkg::IRQ_IDLE;
      doorbell_q   <= 1'b0;
      completion_q <= 1'b0;
    end else begin
      state_q      <= state_d;
      doorbell_q   <= (state_d == mbox_pkg::IRQ_RING);
      completion_q <= (state_d == mbox_pkg::IRQ_DONE);
    end
  end

  assign doorbell_irq_o   = doorbell_q;
  assign completion_irq_o = completion_q;

endmodule

// ==== design/mbox_pkg.sv ====
// Mailbox types
// Vector types for messages, slot indices and counts, and the
// interrupt FSM state encoding

`include "mbox_defines.svh"

package mbox_pkg;

  // One mailbox message
  typedef logic [`MBOX_MSG_W-1:0] msg_t;

  // Read or write slot index
  typedef logic [`MBOX_PTR_W-1:0] ptr_t;

  // Fill level or credit count
  typedef logic [`MBOX_CNT_W-1:0] count_t;

  typedef enum logic [1:0] {
    IRQ_IDLE = 2'd0,
    IRQ_RING = 2'd1,
    IRQ_DONE = 2'd2
  } irq_state_t;

endpackage

// ==== design/mbox_top.sv ====
// Host to cluster mailbox
// Message queue with credit flow control toward the host and
// doorbell and completion interrupts

`timescale 1ns/10ps

module mbox_top (
  input  logic           clk_i,
  input  logic           rst_n_i,
  // Host side
  input  logic           h_push_i,
  input  mbox_pkg::msg_t h_msg_i,
  output logic           h_credit_o,
  input  logic           h_irq_clr_i,
  // Cluster side
  input  logic           c_pop_i,
  output mbox_pkg::msg_t c_msg_o,
  output logic           c_valid_o,
  // Interrupts and status
  output logic           doorbell_irq_o,
  output logic           completion_irq_o,
  output logic           err_overflow_o
);

  logic             push_ok;
  logic             pop_ok;
  mbox_pkg::count_t fill_count;

  mbox_fifo u_fifo (
    .clk_i     ( clk_i      ),
    .rst_n_i   ( rst_n_i    ),
    .push_i    ( h_push_i   ),
    .msg_i     ( h_msg_i    ),
    .pop_i     ( c_pop_i    ),
    .msg_o     ( c_msg_o    ),
    .valid_o   ( c_valid_o  ),
    .push_ok_o ( push_ok    ),
    .pop_ok_o  ( pop_ok     ),
    .count_o   ( fill_count )
  );

  mbox_credit_ctrl u_credit (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .push_i         ( h_push_i       ),
    .push_ok_i      ( push_ok        ),
    .pop_ok_i       ( pop_ok         ),
    .credit_o       ( h_credit_o     ),
    .err_overflow_o ( err_overflow_o )
  );

  mbox_irq_fsm u_irq (
    .clk_i            ( clk_i            ),
    .rst_n_i          ( rst_n_i          ),
    .count_i          ( fill_count       ),
    .clr_i            ( h_irq_clr_i      ),
    .doorbell_irq_o   ( doorbell_irq_o   ),
    .completion_irq_o ( completion_irq_o )
  );

endmodule

// ==== tb.f ====
+incdir+design
design/mbox_pkg.sv
design/mbox_fifo.sv
design/mbox_credit_ctrl.sv
design/mbox_irq_fsm.sv
design/mbox_top.sv
test/mbox_props.sv
test/tb_mbox.sv

// ==== test/mbox_props.sv ====
// Mailbox protocol assertions
// Credit return pairing, exclusive interrupts and the sticky
// overflow flag

`timescale 1ns/10ps

module mbox_props (
  input logic clk_i,
  input logic rst_n_i,
  input logic h_credit_o,
  input logic c_pop_i,
  input logic c_valid_o,
  input logic doorbell_irq_o,
  input logic completion_irq_o,
  input logic err_overflow_o
);

  logic pop_taken;

  assign pop_taken = c_pop_i & c_valid_o;

  // Back to back credits need a pop in each of the two cycles before
  a_credit_pair: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (h_credit_o && $past(h_credit_o)) |-> ($past(pop_taken) && $past(pop_taken, 2)))
    else $error("credit returned twice in a row without two pops");

  a_irq_exclusive: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(doorbell_irq_o && completion_irq_o))
    else $error("doorbell and completion interrupts high together");

  a_err_sticky: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !$fell(err_overflow_o))
    else $error("overflow flag cleared without reset");

endmodule

bind mbox_top mbox_props u_props (
  .clk_i            ( clk_i            ),
  .rst_n_i          ( rst_n_i          ),
  .h_credit_o       ( h_credit_o       ),
  .c_pop_i          ( c_pop_i          ),
  .c_valid_o        ( c_valid_o        ),
  .doorbell_irq_o   ( doorbell_irq_o   ),
  .completion_irq_o ( completion_irq_o ),
  .err_overflow_o   ( err_overflow_o   )
);

// ==== test/tb_mbox.sv ====
// Mailbox testbench
// Runs a table of push, pop and clear sequences against the mailbox
// and checks ordering, credits, interrupts and the overflow flag

`timescale 1ns/10ps
`include "mbox_defines.svh"

module tb_mbox;

  localparam int NUM_ROWS   = 10;
  localparam int WAIT_LIMIT = 40;

  // One table row, expected values follow the stimulus fields
  typedef struct packed {
    int pushes;
    int pops;
    int clr;
    int ring;
    int ovf;
    int end_cnt;
    int credits;
    int db;
    int cp;
  } row_t;

  logic           clk = 1'b0;
  logic           rst_n;
  logic           h_push;
  mbox_pkg::msg_t h_msg;
  logic           h_credit;
  logic           h_irq_clr;
  logic           c_pop;
  mbox_pkg::msg_t c_msg;
  logic           c_valid;
  logic           doorbell_irq;
  logic           completion_irq;
  logic           err_overflow;

  row_t           rows [NUM_ROWS];
  string          row_names [NUM_ROWS];
  int             row_count;
  mbox_pkg::msg_t sb [$];
  logic [15:0]    lfsr_q;
  int             credit_seen;
  int             error_count;
  int             tests_run;
  int             tests_failed;

  mbox_top mbox_top_i (
    .clk_i            ( clk            ),
    .rst_n_i          ( rst_n          ),
    .h_push_i         ( h_push         ),
    .h_msg_i          ( h_msg          ),
    .h_credit_o       ( h_credit       ),
    .h_irq_clr_i      ( h_irq_clr      ),
    .c_pop_i          ( c_pop          ),
    .c_msg_o          ( c_msg          ),
    .c_valid_o        ( c_valid        ),
    .doorbell_irq_o   ( doorbell_irq   ),
    .completion_irq_o ( completion_irq ),
    .err_overflow_o   ( err_overflow   )
  );

  always #20 clk = ~clk;

  // Cycles with a returned credit
  always @(posedge clk) begin
    if (!rst_n) begin
      credit_seen <= 0;
    end else if (h_credit) begin
      credit_seen <= credit_seen + 1;
    end
  end

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  task automatic draw_msg(output mbox_pkg::msg_t m);
    m = '0;
    for (int b = 0; b < `MBOX_MSG_W; b++) begin
      lfsr_q = lfsr_next(lfsr_q);
      m = {m[`MBOX_MSG_W-2:0], lfsr_q[0]};
    end
  endtask

  task automatic check_value(input string test, input string what,
                             input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("FAIL %s %s: expected %0h, actual %0h", test, what, exp, act);
      error_count++;
    end
  endtask

  task automatic add_row(input string name, input int pushes, input int pops,
                         input int clr, input int ring, input int ovf,
                         input int end_cnt, input int credits, input int db,
                         input int cp);
    row_names[row_count] = name;
    rows[row_count] = '{pushes, pops, clr, ring, ovf, end_cnt, credits, db, cp};
    row_count++;
  endtask

  task automatic wait_irq(input string test, input logic exp_db,
                          input logic exp_cp, input string what);
    int n;
    n = 0;
    while ((doorbell_irq !== exp_db || completion_irq !== exp_cp) &&
           n < WAIT_LIMIT) begin
      @(posedge clk);
      #2;
      n++;
    end
    if (doorbell_irq !== exp_db || completion_irq !== exp_cp) begin
      $display("Timed out in %s waiting for %s", test, what);
      error_count++;
    end
  endtask

  // A full queue drops the push, so the scoreboard skips it too
  task automatic push_msg();
    mbox_pkg::msg_t m;
    draw_msg(m);
    if (sb.size() < `MBOX_DEPTH) begin
      sb.push_back(m);
    end
    h_msg  = m;
    h_push = 1'b1;
    @(posedge clk);
    #2;
    h_push = 1'b0;
  endtask

  task automatic pop_msg(input string test, input int ring);
    mbox_pkg::msg_t exp_msg;
    if (sb.size() > 0) begin
      check_value(test, "c_valid", 32'(1'b1), 32'(c_valid));
      if (ring != 0) begin
        check_value(test, "doorbell while waiting", 32'(1'b1), 32'(doorbell_irq));
      end
      exp_msg = sb.pop_front();
      check_value(test, "message", exp_msg, c_msg);
    end else begin
      check_value(test, "c_valid when empty", 32'(1'b0), 32'(c_valid));
    end
    c_pop = 1'b1;
    @(posedge clk);
    #2;
    c_pop = 1'b0;
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests_run++;
    if (error_count != errs_before) begin
      tests_failed++;
    end
    $display("test %-12s done, %0d errors", name, error_count - errs_before);
  endtask

  task automatic run_row(input int i);
    string name;
    row_t  r;
    int    errs_before;
    int    credits_before;
    name           = row_names[i];
    r              = rows[i];
    errs_before    = error_count;
    credits_before = credit_seen;
    for (int k = 0; k < r.pushes; k++) begin
      push_msg();
    end
    if (r.ring != 0) begin
      wait_irq(name, 1'b1, 1'b0, "doorbell after pushes");
    end
    for (int k = 0; k < r.pops; k++) begin
      pop_msg(name, r.ring);
    end
    // Last credit pulse lands one cycle after the last pop
    repeat (2) begin
      @(posedge clk);
      #2;
    end
    check_value(name, "credits", r.credits, credit_seen - credits_before);
    if (r.clr != 0) begin
      wait_irq(name, 1'b0, 1'b1, "completion before clear");
      h_irq_clr = 1'b1;
      @(posedge clk);
      #2;
      h_irq_clr = 1'b0;
    end
    wait_irq(name, r.db[0], r.cp[0], "final interrupt state");
    check_value(name, "doorbell", r.db, 32'(doorbell_irq));
    check_value(name, "completion", r.cp, 32'(completion_irq));
    check_value(name, "overflow flag", r.ovf, 32'(err_overflow));
    check_value(name, "fill count", r.end_cnt, 32'(mbox_top_i.fill_count));
    check_value(name, "c_valid at end", 32'(r.end_cnt != 0), 32'(c_valid));
    report_test(name, errs_before);
  endtask

  initial begin
    int errs_before;
    rst_n        = 1'b0;
    h_push       = 1'b0;
    h_msg        = '0;
    h_irq_clr    = 1'b0;
    c_pop        = 1'b0;
    lfsr_q       = 16'd34;
    row_count    = 0;
    error_count  = 0;
    tests_run    = 0;
    tests_failed = 0;

    //      name          push pop clr ring ovf cnt cred db cp
    add_row("order",         4,  4,  0,  1,  0,  0,  4,  0, 1);
    add_row("ack",           0,  0,  1,  0,  0,  0,  0,  0, 0);
    add_row("empty_pop",     0,  2,  0,  0,  0,  0,  0,  0, 0);
    add_row("partial",       3,  1,  0,  1,  0,  2,  1,  1, 0);
    add_row("drain",         0,  2,  0,  1,  0,  0,  2,  0, 1);
    add_row("clear_busy",    1,  0,  1,  0,  0,  1,  0,  1, 0);
    add_row("drain_one",     0,  1,  0,  1,  0,  0,  1,  0, 1);
    add_row("ack_again",     0,  0,  1,  0,  0,  0,  0,  0, 0);
    add_row("overflow",      5,  5,  0,  1,  1,  0,  4,  0, 1);
    add_row("sticky",        0,  0,  1,  0,  1,  0,  0,  0, 0);

    repeat (8) @(posedge clk);
    #2;
    rst_n = 1'b1;

    errs_before = error_count;
    check_value("reset", "c_valid", 32'(1'b0), 32'(c_valid));
    check_value("reset", "h_credit", 32'(1'b0), 32'(h_credit));
    check_value("reset", "doorbell", 32'(1'b0), 32'(doorbell_irq));
    check_value("reset", "completion", 32'(1'b0), 32'(completion_irq));
    check_value("reset", "overflow flag", 32'(1'b0), 32'(err_overflow));
    report_test("reset", errs_before);

    for (int i = 0; i < row_count; i++) begin
      run_row(i);
    end

    $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, error_count);
    if (error_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule
